/* source/mips_mem_cfg.svh */
`ifndef MIPS_MEM_CFG_SVH
`define MIPS_MEM_CFG_SVH

// data RAM size in 32-bit words
`define MEM_DEPTH_WORDS 256

// extra access-phase cycles before pready, zero is legal
`define MEM_WAIT_STATES 1

`endif

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // MIPS primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_LB  = 6'h20,
        OP_LH  = 6'h21,
        OP_LW  = 6'h23,
        OP_LBU = 6'h24,
        OP_LHU = 6'h25,
        OP_SB  = 6'h28,
        OP_SH  = 6'h29,
        OP_SW  = 6'h2B
    } mem_op_e;

    // request into the stage
    typedef struct packed {
        logic [31:0] instr;   // full instruction word
        logic [31:0] addr;    // effective byte address
        logic [31:0] wdata;   // register value for stores
    } mem_req_t;

    // response out of the stage
    typedef struct packed {
        logic [31:0] rdata;             // extended load data
        logic        addr_error_load;
        logic        addr_error_store;
        logic        bus_error;         // pslverr seen
    } mem_resp_t;

    // APB4 master to slave
    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // APB4 slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* source/mem_control.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_control import mem_pkg::*; (
    input  mem_op_e     op,
    input  logic [1:0]  addr,         // byte offset in word
    input  logic [31:0] wdata,
    input  logic [31:0] mem_rdata,    // raw word from RAM
    output logic        is_load,
    output logic        is_store,
    output logic [3:0]  write_strobe,
    output logic [31:0] write_data,
    output logic [31:0] load_data,
    output logic        addr_error_load,
    output logic        addr_error_store
);

    logic        word_ok;
    logic        half_ok;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign word_ok = (addr == 2'b00);
    assign half_ok = ~addr[0];          // offset 0 or 2

    // addressed byte of the read word
    always_comb begin
        case (addr)
            2'b00:   rd_byte = mem_rdata[7:0];
            2'b01:   rd_byte = mem_rdata[15:8];
            2'b10:   rd_byte = mem_rdata[23:16];
            default: rd_byte = mem_rdata[31:24];
        endcase
    end

    assign rd_half = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        is_load          = 1'b0;
        is_store         = 1'b0;
        write_strobe     = 4'b0000;
        write_data       = '0;
        load_data        = '0;
        addr_error_load  = 1'b0;
        addr_error_store = 1'b0;

        case (op)
            OP_LW: begin
                is_load         = 1'b1;
                addr_error_load = ~word_ok;
                load_data       = word_ok ? mem_rdata : '0;   // word passes through
            end
            OP_LH: begin
                is_load         = 1'b1;
                addr_error_load = ~half_ok;
                if (half_ok) begin
                    load_data = {{16{rd_half[15]}}, rd_half};  // sign extend
                end
            end
            OP_LHU: begin
                is_load         = 1'b1;
                addr_error_load = ~half_ok;
                if (half_ok) begin
                    load_data = {16'h0000, rd_half};
                end
            end
            OP_LB: begin
                is_load   = 1'b1;
                load_data = {{24{rd_byte[7]}}, rd_byte};       // sign extend
            end
            OP_LBU: begin
                is_load   = 1'b1;
                load_data = {24'h000000, rd_byte};
            end
            OP_SW: begin
                is_store         = 1'b1;
                addr_error_store = ~word_ok;
                write_strobe     = word_ok ? 4'b1111 : 4'b0000;
                write_data       = wdata;
            end
            OP_SH: begin
                is_store         = 1'b1;
                addr_error_store = ~half_ok;
                if (half_ok) begin
                    write_strobe = addr[1] ? 4'b1100 : 4'b0011;  // high or low pair
                end
                write_data = {2{wdata[15:0]}};                  // same half in both pairs
            end
            OP_SB: begin
                is_store     = 1'b1;
                write_strobe = 4'b0001 << addr;                 // one lane
                write_data   = {4{wdata[7:0]}};
            end
            default: begin
                // not a memory op, everything stays zero
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/apb_mem_master.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_mem_master import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // request side
    input  logic        req_valid,
    output logic        req_ready,
    input  mem_req_t    req,
    // response side
    output logic        resp_valid,
    input  logic        resp_ready,
    output mem_resp_t   resp,
    // APB
    output apb_req_t    apb_req,
    input  apb_rsp_t    apb_rsp,
    // to formatter
    output mem_op_e     op,
    output logic [1:0]  addr_low,
    output logic [31:0] wdata,
    // from formatter
    input  logic        is_load,
    input  logic        is_store,
    input  logic [3:0]  write_strobe,
    input  logic [31:0] write_data,
    input  logic [31:0] load_data,
    input  logic        addr_error_load,
    input  logic        addr_error_store
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,     // formatter settles on held request
        SETUP,
        ACCESS,
        RESP
    } state_e;

    state_e    state_q;
    state_e    state_d;
    mem_req_t  held_req;
    mem_resp_t resp_q;
    logic      need_access;
    logic      accept;

    assign accept = req_valid & req_ready;

    // aligned load or store goes to the bus
    assign need_access = (is_load & ~addr_error_load) | (is_store & ~addr_error_store);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = DECODE;
            DECODE:  state_d = need_access ? SETUP : RESP;
            SETUP:   state_d = ACCESS;
            ACCESS:  if (apb_rsp.pready) state_d = RESP;
            RESP:    if (resp_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
        end
    end

    assign op       = mem_op_e'(held_req.instr[31:26]);
    assign addr_low = held_req.addr[1:0];
    assign wdata    = held_req.wdata;

    // response register, held until taken
    always_ff @(posedge clk) begin
        if (state_q == DECODE && !need_access) begin
            resp_q.rdata            <= '0;
            resp_q.addr_error_load  <= addr_error_load;
            resp_q.addr_error_store <= addr_error_store;
            resp_q.bus_error        <= 1'b0;
        end else if (state_q == ACCESS && apb_rsp.pready) begin
            resp_q.rdata            <= (is_load && !apb_rsp.pslverr) ? load_data : '0;
            resp_q.addr_error_load  <= 1'b0;
            resp_q.addr_error_store <= 1'b0;
            resp_q.bus_error        <= apb_rsp.pslverr;
        end
    end

    // APB drive, stable from held request through the whole transfer
    always_comb begin
        apb_req.paddr   = held_req.addr;
        apb_req.psel    = (state_q == SETUP) || (state_q == ACCESS);
        apb_req.penable = (state_q == ACCESS);
        apb_req.pwrite  = is_store;
        apb_req.pwdata  = write_data;
        apb_req.pstrb   = is_store ? write_strobe : 4'b0000;  // reads carry no strobe
    end

    assign req_ready  = (state_q == IDLE);
    assign resp_valid = (state_q == RESP);
    assign resp       = resp_q;

endmodule

`default_nettype wire

/* source/data_ram_apb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_cfg.svh"

module data_ram_apb import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    localparam int DEPTH = `MEM_DEPTH_WORDS;
    localparam int WAITS = `MEM_WAIT_STATES;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(WAITS + 2);

    logic [31:0]      mem [DEPTH];
    logic [29:0]      word_addr;
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             access;
    logic             ready;
    logic [CNT_W-1:0] wait_cnt;

    assign word_addr = apb_req.paddr[31:2];     // byte offset ignored
    assign in_range  = (word_addr < 30'(DEPTH));
    assign idx       = word_addr[IDX_W-1:0];
    assign access    = apb_req.psel & apb_req.penable;
    assign ready     = access & (wait_cnt == CNT_W'(WAITS));

    // counts access cycles, cleared at end of each transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (ready || !access) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && apb_req.pwrite && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (apb_req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = ready;
        apb_rsp.pslverr = ready & ~in_range;    // beyond depth
        apb_rsp.prdata  = (ready && !apb_req.pwrite && in_range) ? mem[idx] : '0;
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  mem_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output mem_resp_t resp
);

    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    mem_op_e     op;
    logic [1:0]  addr_low;
    logic [31:0] wdata;
    logic        is_load;
    logic        is_store;
    logic [3:0]  write_strobe;
    logic [31:0] write_data;
    logic [31:0] load_data;
    logic        addr_error_load;
    logic        addr_error_store;

    apb_mem_master u_master (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req              (req),
        .resp_valid       (resp_valid),
        .resp_ready       (resp_ready),
        .resp             (resp),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .op               (op),
        .addr_low         (addr_low),
        .wdata            (wdata),
        .is_load          (is_load),
        .is_store         (is_store),
        .write_strobe     (write_strobe),
        .write_data       (write_data),
        .load_data        (load_data),
        .addr_error_load  (addr_error_load),
        .addr_error_store (addr_error_store)
    );

    mem_control u_mem_control (
        .op               (op),
        .addr             (addr_low),
        .wdata            (wdata),
        .mem_rdata        (apb_rsp.prdata),   // raw word straight from the bus
        .is_load          (is_load),
        .is_store         (is_store),
        .write_strobe     (write_strobe),
        .write_data       (write_data),
        .load_data        (load_data),
        .addr_error_load  (addr_error_load),
        .addr_error_store (addr_error_store)
    );

    data_ram_apb u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

`default_nettype wire

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_cfg.svh"

module mem_stage_tb import mem_pkg::*; ();

    localparam int DEPTH   = `MEM_DEPTH_WORDS;
    localparam int TIMEOUT = 200;               // cycles per wait loop

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    mem_req_t  req;
    logic      resp_valid;
    logic      resp_ready;
    mem_resp_t resp;

    logic [31:0] model_mem [DEPTH];             // expected RAM contents
    logic [5:0]  mem_ops [8]    = '{OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU, OP_SW, OP_SH, OP_SB};
    logic [5:0]  nonmem_ops [8] = '{6'h00, 6'h02, 6'h08, 6'h0F, 6'h22, 6'h26, 6'h2A, 6'h2E};
    int          error_count;
    int          check_count;
    int          stall_count;
    int          test_errors;
    logic        timed_out;
    logic        bp_mode;                       // long resp_ready low stretches

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic logic pick_ready();
        if (bp_mode) begin
            return ($urandom % 4) == 0;
        end else begin
            return ($urandom % 4) != 0;
        end
    endfunction

    // access size in bytes, zero for anything that is not a load or store
    function automatic int op_size(input logic [5:0] opc);
        case (opc)
            OP_LW, OP_SW:         return 4;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LB, OP_LBU, OP_SB: return 1;
            default:              return 0;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input int idx, input int off);
        return (32'(idx) << 2) | 32'(off);
    endfunction

    // reference model, updates model_mem on a successful store
    function automatic mem_resp_t predict(input logic [5:0] opc, input logic [31:0] addr,
                                          input logic [31:0] wd);
        mem_resp_t   r;
        int          size;
        int          off;
        int          widx;
        logic        store;
        logic        sext;
        logic [31:0] word;
        logic [31:0] val;
        r     = '0;
        size  = op_size(opc);
        off   = int'(addr[1:0]);
        store = (opc == OP_SW) || (opc == OP_SH) || (opc == OP_SB);
        sext  = (opc == OP_LB) || (opc == OP_LH);
        if (size == 0) begin
            return r;                           // not a memory op
        end
        if (off % size != 0) begin
            r.addr_error_load  = ~store;
            r.addr_error_store = store;
            return r;
        end
        if (addr[31:2] >= 30'(DEPTH)) begin
            r.bus_error = 1'b1;
            return r;
        end
        widx = int'(addr[31:2]);
        word = model_mem[widx];
        if (store) begin
            for (int b = 0; b < size; b++) begin
                word[8*(off+b) +: 8] = wd[8*b +: 8];
            end
            model_mem[widx] = word;
            return r;
        end
        val = word >> (8 * off);
        if (size == 1) begin
            val = sext ? {{24{val[7]}}, val[7:0]} : {24'h0, val[7:0]};
        end else if (size == 2) begin
            val = sext ? {{16{val[15]}}, val[15:0]} : {16'h0, val[15:0]};
        end
        r.rdata = val;
        return r;
    endfunction

    // one request through the handshakes, inputs change 2 ns after the edge
    task automatic run_access(input logic [5:0] opc, input logic [31:0] addr,
                              input logic [31:0] wd, output mem_resp_t got);
        int        cycles;
        mem_resp_t held;
        logic      holding;
        got = '0;
        if (timed_out) begin
            return;
        end
        req.instr = {opc, 26'($urandom)};
        req.addr  = addr;
        req.wdata = wd;
        req_valid = 1'b1;
        cycles    = 0;
        while (!req_ready) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: the stage never accepted the request at %0t ns", $time);
                timed_out = 1'b1;
                return;
            end
        end
        @(posedge clk);                         // request taken on this edge
        #2;
        req_valid  = 1'b0;
        req        = {$urandom, $urandom, $urandom};   // junk while busy
        resp_ready = pick_ready();
        holding    = 1'b0;
        held       = '0;
        cycles     = 0;
        while (!(resp_valid && resp_ready)) begin
            if (resp_valid) begin
                check(32'(req_ready), 32'h0, "req_ready low under back-pressure");
                if (holding) begin
                    check(32'(resp === held), 32'h1, "response stable under back-pressure");
                end
                held    = resp;
                holding = 1'b1;
                stall_count++;
            end
            @(posedge clk);
            #2;
            resp_ready = pick_ready();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: no response came back at %0t ns", $time);
                timed_out = 1'b1;
                return;
            end
        end
        got = resp;
        if (holding) begin
            check(32'(resp === held), 32'h1, "response stable when taken");
        end
        @(posedge clk);                         // response taken
        #2;
        resp_ready = 1'b0;
    endtask

    task automatic access_and_check(input logic [5:0] opc, input logic [31:0] addr,
                                    input logic [31:0] wd, input string what);
        mem_resp_t expected;
        mem_resp_t got;
        string     msg;
        expected = predict(opc, addr, wd);
        run_access(opc, addr, wd, got);
        if (timed_out) begin
            return;
        end
        msg = $sformatf("%s op %h addr %h", what, opc, addr);
        check(got.rdata, expected.rdata, {msg, " rdata"});
        check({29'h0, got.addr_error_load, got.addr_error_store, got.bus_error},
              {29'h0, expected.addr_error_load, expected.addr_error_store, expected.bus_error},
              {msg, " flags"});
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    initial begin
        int         idx;
        int         off;
        int         size;
        int         stalls_before;
        logic [5:0] opc;
        void'($urandom(40092));
        error_count = 0;
        check_count = 0;
        stall_count = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        bp_mode     = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        resp_ready  = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check(32'(req_ready), 32'h1, "req_ready after reset");
        check(32'(resp_valid), 32'h0, "resp_valid after reset");

        for (int i = 0; i < DEPTH; i++) begin  // fill so RAM and model agree
            access_and_check(OP_SW, make_addr(i, 0), $urandom, "fill");
        end
        for (int n = 0; n < 40; n++) begin
            idx = $urandom % DEPTH;
            access_and_check(OP_SW, make_addr(idx, 0), $urandom, "word store");
            access_and_check(OP_LW, make_addr(idx, 0), 32'h0, "word load");
        end
        report_test("word round trip");

        for (int n = 0; n < 40; n++) begin
            idx = $urandom % DEPTH;
            opc = ($urandom % 2) ? OP_SB : OP_SH;
            off = $urandom % 4;
            if (opc == OP_SH) begin
                off = off & 2;
            end
            access_and_check(opc, make_addr(idx, off), $urandom, "sub-word store");
            access_and_check(OP_LW, make_addr(idx, 0), 32'h0, "read back");
        end
        report_test("sub-word stores");

        for (int n = 0; n < 16; n++) begin
            idx = $urandom % DEPTH;
            access_and_check(OP_SW, make_addr(idx, 0), $urandom, "seed word");
            for (int o = 0; o < 4; o++) begin
                access_and_check(OP_LB, make_addr(idx, o), 32'h0, "byte load");
                access_and_check(OP_LBU, make_addr(idx, o), 32'h0, "unsigned byte load");
                if (o % 2 == 0) begin
                    access_and_check(OP_LH, make_addr(idx, o), 32'h0, "half load");
                    access_and_check(OP_LHU, make_addr(idx, o), 32'h0, "unsigned half load");
                end
            end
        end
        report_test("load extension");

        for (int n = 0; n < 20; n++) begin
            idx = $urandom % DEPTH;
            case ($urandom % 5)
                0:       opc = OP_LW;
                1:       opc = OP_SW;
                2:       opc = OP_LH;
                3:       opc = OP_LHU;
                default: opc = OP_SH;
            endcase
            if (op_size(opc) == 4) begin
                off = 1 + ($urandom % 3);
            end else begin
                off = ($urandom % 2) ? 1 : 3;
            end
            access_and_check(opc, make_addr(idx, off), $urandom, "misaligned");
            access_and_check(OP_LW, make_addr(idx, 0), 32'h0, "unchanged after misaligned");
        end
        report_test("misalignment");

        for (int n = 0; n < 20; n++) begin
            opc  = mem_ops[$urandom % 8];
            size = op_size(opc);
            idx  = DEPTH + ($urandom % 1024);
            off  = ($urandom % 4) & ~(size - 1);
            access_and_check(opc, make_addr(idx, off), $urandom, "out of range");
            access_and_check(OP_LW, make_addr(idx % DEPTH, 0), 32'h0, "alias unchanged");
        end
        for (int n = 0; n < 10; n++) begin
            opc = nonmem_ops[$urandom % 8];
            access_and_check(opc, $urandom, $urandom, "non-memory op");
        end
        report_test("bus error and non-memory");

        bp_mode       = 1'b1;
        stalls_before = stall_count;
        for (int n = 0; n < 30; n++) begin
            opc  = ($urandom % 8 == 0) ? nonmem_ops[$urandom % 8] : mem_ops[$urandom % 8];
            size = (op_size(opc) == 0) ? 1 : op_size(opc);
            idx  = ($urandom % 16 == 0) ? DEPTH + ($urandom % 64) : $urandom % DEPTH;
            off  = ($urandom % 4) & ~(size - 1);
            access_and_check(opc, make_addr(idx, off), $urandom, "back-pressure");
        end
        bp_mode = 1'b0;
        if (!timed_out) begin
            check(32'(stall_count > stalls_before), 32'h1, "back-pressure stalls seen");
        end
        report_test("back-pressure");

        $display("checks %0d, errors %0d, stalls %0d", check_count, error_count, stall_count);
        if (timed_out || error_count != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_stage.f */
+incdir+source
source/mem_pkg.sv
source/mem_control.sv
source/apb_mem_master.sv
source/data_ram_apb.sv
source/mem_stage.sv
verification/mem_stage_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module mem_stage_tb \
		-f mem_stage.f -o mem_stage_sim
	@out="$$(./obj_dir/mem_stage_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
